// ==== bench/blit_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blit_defs.svh"

module blit_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   is_busy,
    input blit_pkg::axil_rd_req_t axi_req,
    input blit_pkg::axil_rd_rsp_t axi_rsp,
    input blit_pkg::fb_write_t    fb
);
    import blit_pkg::*;

    // AR request holds until accepted
    assert property (@(posedge clk) disable iff (rst)
        axi_req.arvalid && !axi_rsp.arready |=> axi_req.arvalid)
        else $error("arvalid dropped before arready");

    assert property (@(posedge clk) disable iff (rst)
        axi_req.arvalid && !axi_rsp.arready |=> $stable(axi_req.araddr))
        else $error("araddr changed while waiting for arready");

    assert property (@(posedge clk) disable iff (rst)
        fb.write |-> (fb.x < coord_t'(`BLIT_FB_WIDTH)) && (fb.y < coord_t'(`BLIT_FB_HEIGHT)))
        else $error("framebuffer write outside the screen");

    // first cycle out of reset
    assert property (@(posedge clk)
        $fell(rst) |-> !is_busy && !fb.write && !axi_req.arvalid && !axi_req.rready)
        else $error("outputs not idle after reset");

endmodule

bind blit_top blit_assertions assertions_inst (
    .clk     (clk),
    .rst     (rst),
    .is_busy (is_busy),
    .axi_req (axi_req),
    .axi_rsp (axi_rsp),
    .fb      (fb)
);

`default_nettype wire

// ==== bench/blit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blit_defs.svh"

module blit_tb;
    import blit_pkg::*;

    localparam int NUM_CMDS = 24;
    localparam int MAX_CYCLES = NUM_CMDS * 64 * 12 + 500;
    localparam int FB_W = `BLIT_FB_WIDTH;
    localparam int FB_H = `BLIT_FB_HEIGHT;

    logic         clk;
    logic         rst;
    draw_cmd_t    cmd;
    logic         command_draw;
    logic         is_busy;
    axil_rd_req_t axi_req;
    axil_rd_rsp_t axi_rsp;
    colour_t      ct_address;
    colour_t      ct_colour;
    fb_write_t    fb;

    bus_word_t mem [256];
    colour_t   ct_table [256];
    fb_write_t expected [$];
    integer    seed = 32'h2268;
    int        errors = 0;
    int        checked = 0;
    int        cycles = 0;
    logic      drawing = 1'b0;  // cleared once is_busy has fallen
    string     test_name;

    blit_top blit_top_inst (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd),
        .command_draw (command_draw),
        .is_busy      (is_busy),
        .axi_req      (axi_req),
        .axi_rsp      (axi_rsp),
        .ct_address   (ct_address),
        .ct_colour    (ct_colour),
        .fb           (fb)
    );

    // address arrives already registered by the DUT
    assign ct_colour = ct_table[ct_address[7:0]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: DUT still busy after %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // msb-first field at the modelled word and offset
    function automatic colour_t mem_field(bus_addr_t start, int sx, int sy, int img_w, int bpp);
        int        bit_addr;
        int        lsb;
        bus_word_t word;
        bus_word_t mask;
        bit_addr = (sx + img_w * sy) * bpp;
        word = mem[8'(int'(start / 4) + bit_addr / 32)];
        lsb = 32 - bit_addr % 32 - bpp;
        mask = (32'h1 << bpp) - 32'h1;
        return colour_t'((word >> lsb) & mask);
    endfunction

    task automatic random_cmd(input int n, output draw_cmd_t c);
        c = '0;
        c.sheet_x = coord_t'(rand_below(8));
        c.sheet_y = coord_t'(rand_below(8));
        c.width = coord_t'(1 + rand_below(8));
        c.height = coord_t'(1 + rand_below(8));
        c.image_width = coord_t'(16 + rand_below(16));
        c.image_start = bus_addr_t'(4 * rand_below(32));  // whole sheet fits in mem
        c.screen_x = coord_t'(rand_below(4) == 0 ? FB_W - 6 + rand_below(10) : rand_below(FB_W));
        c.screen_y = coord_t'(rand_below(4) == 0 ? FB_H - 6 + rand_below(10) : rand_below(FB_H));
        if (n == 5) c.screen_x = coord_t'(FB_W + 3);  // fully off the right edge
        if (n == 11) c.screen_y = coord_t'(FB_H + 5);
        case (rand_below(5))
            0: c.bpp = BPP_1;
            1: c.bpp = BPP_2;
            2: c.bpp = BPP_4;
            3: c.bpp = BPP_8;
            default: c.bpp = BPP_16;
        endcase
        c.mirror_x = 1'(rand_below(2));
        c.mirror_y = 1'(rand_below(2));
        c.ct_enable = 1'(rand_below(2));
        c.ct_offset = colour_t'($random(seed));
        c.colour_src = (rand_below(4) == 0) ? FILL : MEMORY;
        c.fill_colour = colour_t'($random(seed));
    endtask

    // expected writes in walk order with y outer
    task automatic build_expected(input draw_cmd_t c);
        int        cx;
        int        cy;
        int        sx;
        int        sy;
        colour_t   f;
        fb_write_t w;
        for (cy = 0; cy < int'(c.height); cy++) begin
            for (cx = 0; cx < int'(c.width); cx++) begin
                sx = c.mirror_x ? int'(c.screen_x) + int'(c.width) - 1 - cx
                                : int'(c.screen_x) + cx;
                sy = c.mirror_y ? int'(c.screen_y) + int'(c.height) - 1 - cy
                                : int'(c.screen_y) + cy;
                if (sx < FB_W && sy < FB_H) begin
                    f = mem_field(c.image_start, int'(c.sheet_x) + cx, int'(c.sheet_y) + cy,
                                  int'(c.image_width), int'(c.bpp));
                    w.x = coord_t'(sx);
                    w.y = coord_t'(sy);
                    w.write = 1'b1;
                    if (c.colour_src == FILL)
                        w.colour = c.fill_colour;
                    else if (c.ct_enable)
                        w.colour = ct_table[8'(int'(f) * `BLIT_CT_STEP + int'(c.ct_offset))];
                    else
                        w.colour = f;
                    expected.push_back(w);
                end
            end
        end
    endtask

    task automatic check_write();
        fb_write_t exp_w;
        if (!drawing) begin
            errors++;
            $display("write at (%0d,%0d) arrived after is_busy had fallen", fb.x, fb.y);
        end
        if (expected.size() == 0) begin
            errors++;
            $display("write at (%0d,%0d) with no pixel left to draw", fb.x, fb.y);
        end else begin
            exp_w = expected.pop_front();
            checked++;
            if (fb.x != exp_w.x || fb.y != exp_w.y) begin
                errors++;
                $display("[FAIL] %s position: expected (%0d,%0d) actual (%0d,%0d)",
                         test_name, exp_w.x, exp_w.y, fb.x, fb.y);
            end
            if (fb.colour != exp_w.colour) begin
                errors++;
                $display("[FAIL] %s colour at (%0d,%0d): expected %h actual %h",
                         test_name, exp_w.x, exp_w.y, exp_w.colour, fb.colour);
            end
        end
    endtask

    // one-cycle strobe is stable around the falling edge
    always @(negedge clk) begin
        if (!rst && fb.write) check_write();
    end

    // AXI-Lite read slave with random wait states
    initial begin : axi_slave
        bus_addr_t rd_addr;
        int        delay;
        axi_rsp = '0;
        forever begin
            @(posedge clk);
            #2;
            if (!rst && axi_req.arvalid) begin
                delay = rand_below(4);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                rd_addr = axi_req.araddr;
                axi_rsp.arready = 1'b1;
                @(posedge clk);
                #2;
                axi_rsp.arready = 1'b0;
                delay = rand_below(4);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                axi_rsp.rdata = mem[rd_addr[9:2]];
                axi_rsp.rvalid = 1'b1;
                if (!axi_req.rready) begin
                    errors++;
                    $display("read data returned while rready was low");
                end
                @(posedge clk);
                #2;
                axi_rsp.rvalid = 1'b0;
            end
        end
    end

    initial begin
        draw_cmd_t c;
        int        n;
        int        i;
        rst = 1'b1;
        cmd = '0;
        command_draw = 1'b0;
        for (i = 0; i < 256; i++) begin
            mem[i] = bus_word_t'($random(seed));
            ct_table[i] = colour_t'($random(seed));
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (n = 0; n < NUM_CMDS; n++) begin
            random_cmd(n, c);
            test_name = $sformatf("cmd%0d bpp%0d mx%0d my%0d ct%0d src%0d", n, c.bpp,
                                  c.mirror_x, c.mirror_y, c.ct_enable, c.colour_src);
            build_expected(c);
            drawing = 1'b1;
            cmd = c;
            command_draw = 1'b1;
            @(posedge clk);
            #2;
            command_draw = 1'b0;
            while (is_busy) begin
                @(posedge clk);
                #2;
            end
            drawing = 1'b0;
            if (expected.size() != 0) begin
                errors++;
                $display("[FAIL] %s pending writes at idle: expected 0 actual %0d",
                         test_name, expected.size());
                expected.delete();
            end
            repeat (2) begin  // idle gap, late writes land here
                @(posedge clk);
                #2;
            end
        end
        $display("%0d writes checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+source
source/blit_pkg.sv
source/blit_rect_walker.sv
source/blit_address.sv
source/blit_fetch.sv
source/blit_pixel_out.sv
source/blit_top.sv
bench/blit_assertions.sv
bench/blit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the blitter testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module blit_tb -o blit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/blit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** FAILED ***" sim.log; then
    exit 1
fi
exit 0

// ==== source/blit_address.sv ====
`timescale 1ns/1ps
`default_nettype none

module blit_address (
    input  logic                 clk,
    input  logic                 rst,
    input  blit_pkg::draw_cmd_t  cmd,
    input  blit_pkg::sheet_pos_t in_pos,
    input  logic                 in_valid,
    output logic                 in_ready,
    output blit_pkg::fetch_req_t out_req,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import blit_pkg::*;

    typedef enum logic [1:0] {
        EMPTY,
        FULL,
        BUF_FULL
    } skid_state_e;

    skid_state_e state;

    bus_addr_t  index;
    bus_addr_t  bit_addr;
    bus_addr_t  byte_addr;
    fetch_req_t req;
    fetch_req_t buf_req;  // second entry
    logic       in_xfer;
    logic       out_xfer;

    assign index = bus_addr_t'(in_pos.sheet_x)
                 + bus_addr_t'(cmd.image_width) * bus_addr_t'(in_pos.sheet_y);
    assign bit_addr = index * bus_addr_t'(cmd.bpp);
    assign byte_addr = cmd.image_start + (bit_addr >> 3);

    assign req.addr = {byte_addr[31:2], 2'b00};
    assign req.bit_off = bit_addr[4:0];
    assign req.screen = in_pos.screen;

    assign in_xfer = in_valid && in_ready;
    assign out_xfer = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= EMPTY;
            in_ready <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            case (state)
                EMPTY: begin
                    in_ready <= 1'b1;
                    if (in_xfer) begin
                        out_valid <= 1'b1;
                        state <= FULL;
                    end
                end
                FULL: begin
                    if (in_xfer && !out_xfer) begin
                        in_ready <= 1'b0;  // stalled, park the new entry
                        state <= BUF_FULL;
                    end else if (out_xfer && !in_xfer) begin
                        out_valid <= 1'b0;
                        state <= EMPTY;
                    end
                end
                BUF_FULL: begin
                    if (out_xfer) begin
                        in_ready <= 1'b1;
                        state <= FULL;
                    end
                end
                default: state <= EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer && (state == EMPTY || out_xfer)) begin
            out_req <= req;
        end else if (in_xfer) begin
            buf_req <= req;
        end else if (state == BUF_FULL && out_xfer) begin
            out_req <= buf_req;
        end
    end

endmodule

`default_nettype wire

// ==== source/blit_defs.svh ====
`ifndef BLIT_DEFS_SVH
`define BLIT_DEFS_SVH

// framebuffer size in pixels, used for clipping
`define BLIT_FB_WIDTH 400
`define BLIT_FB_HEIGHT 240

// AXI-Lite data width
`define BLIT_WORD_BITS 32

// colour table entries are two address units apart
`define BLIT_CT_STEP 2

`endif

// ==== source/blit_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blit_defs.svh"

module blit_fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  blit_pkg::draw_cmd_t    cmd,
    input  blit_pkg::fetch_req_t   in_req,
    input  logic                   in_valid,
    output logic                   in_ready,
    output blit_pkg::axil_rd_req_t axi_req,
    input  blit_pkg::axil_rd_rsp_t axi_rsp,
    output blit_pkg::pixel_t       out_pix,
    output logic                   out_valid,
    input  logic                   out_ready
);
    import blit_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        ADDR,
        DATA,
        HIT,
        HOLD
    } fetch_state_e;

    fetch_state_e state;

    fetch_req_t req_q;
    bus_addr_t  cache_addr;
    bus_word_t  cache_word;
    logic       cache_valid;
    logic       arvalid_q;
    logic       rready_q;
    logic       hit;

    // msb-first field, top bit sits at bit_off below bit 31
    function automatic colour_t extract_field(bus_word_t word, logic [4:0] bit_off,
                                              bpp_e bpp);
        bus_word_t aligned;
        aligned = word << bit_off;
        return colour_t'(aligned >> (6'(`BLIT_WORD_BITS) - 6'(bpp)));
    endfunction

    assign hit = cache_valid && (cache_addr == in_req.addr);

    assign axi_req.araddr = req_q.addr;
    assign axi_req.arvalid = arvalid_q;
    assign axi_req.rready = rready_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            in_ready <= 1'b0;
            out_valid <= 1'b0;
            arvalid_q <= 1'b0;
            rready_q <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    in_ready <= 1'b1;
                    if (in_valid && in_ready) begin
                        in_ready <= 1'b0;
                        if (hit) begin
                            state <= HIT;
                        end else begin
                            arvalid_q <= 1'b1;
                            state <= ADDR;
                        end
                    end
                end
                ADDR: begin
                    if (axi_rsp.arready) begin
                        arvalid_q <= 1'b0;
                        rready_q <= 1'b1;
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (axi_rsp.rvalid) begin
                        rready_q <= 1'b0;
                        cache_valid <= 1'b1;
                        out_valid <= 1'b1;
                        state <= HOLD;
                    end
                end
                HIT: begin
                    out_valid <= 1'b1;
                    state <= HOLD;
                end
                HOLD: begin
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        in_ready <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && in_valid && in_ready) begin
            req_q <= in_req;
        end
        if (state == DATA && axi_rsp.rvalid) begin
            cache_addr <= req_q.addr;
            cache_word <= axi_rsp.rdata;
            out_pix.field <= extract_field(axi_rsp.rdata, req_q.bit_off, cmd.bpp);
            out_pix.screen <= req_q.screen;
        end else if (state == HIT) begin
            out_pix.field <= extract_field(cache_word, req_q.bit_off, cmd.bpp);
            out_pix.screen <= req_q.screen;
        end
    end

endmodule

`default_nettype wire

// ==== source/blit_pixel_out.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blit_defs.svh"

module blit_pixel_out (
    input  logic                clk,
    input  logic                rst,
    input  blit_pkg::draw_cmd_t cmd,
    input  blit_pkg::pixel_t    in_pix,
    input  logic                in_valid,
    output logic                in_ready,
    output blit_pkg::colour_t   ct_address,
    input  blit_pkg::colour_t   ct_colour,
    output blit_pkg::fb_write_t fb
);
    import blit_pkg::*;

    logic        pend;
    colour_t     field_q;
    screen_pos_t pos_q;
    colour_t     colour;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready <= 1'b0;
            pend <= 1'b0;
        end else begin
            in_ready <= 1'b1;  // framebuffer never stalls
            pend <= in_valid && in_ready;
        end
    end

    // table entry arrives one cycle after the address
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            ct_address <= colour_t'(in_pix.field * `BLIT_CT_STEP) + cmd.ct_offset;
            field_q <= in_pix.field;
            pos_q <= in_pix.screen;
        end
    end

    always_comb begin
        if (cmd.colour_src == FILL) begin
            colour = cmd.fill_colour;
        end else if (cmd.ct_enable) begin
            colour = ct_colour;
        end else begin
            colour = field_q;  // raw field
        end
    end

    assign fb.x = pos_q.x;
    assign fb.y = pos_q.y;
    assign fb.colour = colour;
    assign fb.write = pend;

endmodule

`default_nettype wire

// ==== source/blit_pkg.sv ====
`default_nettype none
`include "blit_defs.svh"

package blit_pkg;

    typedef logic [15:0] coord_t;
    typedef logic [31:0] bus_addr_t;
    typedef logic [`BLIT_WORD_BITS-1:0] bus_word_t;
    typedef logic [15:0] colour_t;

    typedef enum logic [4:0] {
        BPP_1  = 5'd1,
        BPP_2  = 5'd2,
        BPP_4  = 5'd4,
        BPP_8  = 5'd8,
        BPP_16 = 5'd16
    } bpp_e;

    typedef enum logic {
        MEMORY,
        FILL
    } colour_src_e;

    typedef struct packed {
        coord_t      sheet_x;
        coord_t      sheet_y;
        coord_t      screen_x;
        coord_t      screen_y;
        coord_t      width;
        coord_t      height;
        coord_t      image_width;  // sheet row length in pixels
        bus_addr_t   image_start;
        bpp_e        bpp;
        logic        mirror_x;
        logic        mirror_y;
        logic        ct_enable;
        colour_t     ct_offset;
        colour_src_e colour_src;
        colour_t     fill_colour;
    } draw_cmd_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } screen_pos_t;

    typedef struct packed {
        coord_t      sheet_x;
        coord_t      sheet_y;
        screen_pos_t screen;
    } sheet_pos_t;

    typedef struct packed {
        bus_addr_t   addr;     // word aligned
        logic [4:0]  bit_off;  // field msb, counted down from bit 31
        screen_pos_t screen;
    } fetch_req_t;

    typedef struct packed {
        colour_t     field;
        screen_pos_t screen;
    } pixel_t;

    typedef struct packed {
        bus_addr_t araddr;
        logic      arvalid;
        logic      rready;
    } axil_rd_req_t;

    typedef struct packed {
        logic      arready;
        logic      rvalid;
        bus_word_t rdata;
    } axil_rd_rsp_t;

    typedef struct packed {
        coord_t  x;
        coord_t  y;
        colour_t colour;
        logic    write;
    } fb_write_t;

endpackage

`default_nettype wire

// ==== source/blit_rect_walker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blit_defs.svh"

module blit_rect_walker (
    input  logic                 clk,
    input  logic                 rst,
    input  blit_pkg::draw_cmd_t  cmd,
    input  logic                 start,
    output logic                 idle,
    output blit_pkg::sheet_pos_t out_pos,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import blit_pkg::*;

    typedef enum logic {
        IDLE,
        WALK
    } walk_state_e;

    walk_state_e state;

    coord_t sheet_x0;
    coord_t sheet_y0;
    coord_t scr_x0;
    coord_t scr_y0;
    coord_t max_x;  // inclusive
    coord_t max_y;  // inclusive
    logic   mirror_x;
    logic   mirror_y;
    coord_t cnt_x;
    coord_t cnt_y;
    coord_t scr_x;
    coord_t scr_y;
    logic   on_screen;
    logic   step;
    logic   last;

    // mirrored walk counts from the far edge
    assign scr_x = mirror_x ? scr_x0 + max_x - cnt_x : scr_x0 + cnt_x;
    assign scr_y = mirror_y ? scr_y0 + max_y - cnt_y : scr_y0 + cnt_y;

    assign on_screen = (scr_x < coord_t'(`BLIT_FB_WIDTH)) && (scr_y < coord_t'(`BLIT_FB_HEIGHT));
    assign last = (cnt_x == max_x) && (cnt_y == max_y);

    // clipped positions pass without waiting on ready
    assign step = (state == WALK) && (out_ready || !on_screen);

    assign idle = (state == IDLE);
    assign out_valid = (state == WALK) && on_screen;

    assign out_pos.sheet_x = sheet_x0 + cnt_x;
    assign out_pos.sheet_y = sheet_y0 + cnt_y;
    assign out_pos.screen.x = scr_x;
    assign out_pos.screen.y = scr_y;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start && cmd.width != '0 && cmd.height != '0) begin
                        state <= WALK;
                    end
                end
                WALK: begin
                    if (step && last) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            sheet_x0 <= cmd.sheet_x;
            sheet_y0 <= cmd.sheet_y;
            scr_x0 <= cmd.screen_x;
            scr_y0 <= cmd.screen_y;
            max_x <= cmd.width - 16'd1;
            max_y <= cmd.height - 16'd1;
            mirror_x <= cmd.mirror_x;
            mirror_y <= cmd.mirror_y;
            cnt_x <= '0;
            cnt_y <= '0;
        end else if (step) begin
            if (cnt_x == max_x) begin  // next row
                cnt_x <= '0;
                cnt_y <= cnt_y + 16'd1;
            end else begin
                cnt_x <= cnt_x + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/blit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module blit_top (
    input  logic                   clk,
    input  logic                   rst,
    input  blit_pkg::draw_cmd_t    cmd,
    input  logic                   command_draw,
    output logic                   is_busy,
    output blit_pkg::axil_rd_req_t axi_req,
    input  blit_pkg::axil_rd_rsp_t axi_rsp,
    output blit_pkg::colour_t      ct_address,
    input  blit_pkg::colour_t      ct_colour,
    output blit_pkg::fb_write_t    fb
);
    import blit_pkg::*;

    logic       start;
    logic       walk_idle;
    sheet_pos_t walk_pos;
    logic       walk_valid;
    logic       addr_ready;
    fetch_req_t addr_req;
    logic       addr_valid;
    logic       fetch_ready;
    pixel_t     fetch_pix;
    logic       fetch_valid;
    logic       pix_ready;
    logic       fetch_pending;

    assign start = command_draw && !is_busy;

    // fetch holds ready low while a pixel is in flight; pix_ready masks the reset cycle
    assign fetch_pending = pix_ready && !fetch_ready;

    assign is_busy = !walk_idle || walk_valid || addr_valid || fetch_pending
                   || fetch_valid || fb.write;

    blit_rect_walker walker_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .start     (start),
        .idle      (walk_idle),
        .out_pos   (walk_pos),
        .out_valid (walk_valid),
        .out_ready (addr_ready)
    );

    blit_address address_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .in_pos    (walk_pos),
        .in_valid  (walk_valid),
        .in_ready  (addr_ready),
        .out_req   (addr_req),
        .out_valid (addr_valid),
        .out_ready (fetch_ready)
    );

    blit_fetch fetch_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .in_req    (addr_req),
        .in_valid  (addr_valid),
        .in_ready  (fetch_ready),
        .axi_req   (axi_req),
        .axi_rsp   (axi_rsp),
        .out_pix   (fetch_pix),
        .out_valid (fetch_valid),
        .out_ready (pix_ready)
    );

    blit_pixel_out pixel_out_inst (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .in_pix     (fetch_pix),
        .in_valid   (fetch_valid),
        .in_ready   (pix_ready),
        .ct_address (ct_address),
        .ct_colour  (ct_colour),
        .fb         (fb)
    );

endmodule

`default_nettype wire
